// File: Makefile
# Verilator simulation of the C3SRAM subsystem

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		--top-module c3sram_tb -Mdir obj_dir -f files.f
	./obj_dir/Vc3sram_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: files.f
hw/c3sram_pkg.sv
hw/sram_ctrl_if.sv
hw/cmd_ingress.sv
hw/wr_controller.sv
hw/c3sram_array.sv
hw/rd_egress.sv
hw/c3sram_top.sv
verification/tb_clkgen.sv
verification/c3sram_checker.sv
verification/c3sram_tb.sv

// File: hw/c3sram_array.sv
// ##########################################################
// Bitcell array model
// Register array that commits write data under wl, w2b and
// precharge, and senses the selected row under saen
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module c3sram_array (
    input  logic                            clk,
    input  logic                            nrst,
    sram_ctrl_if.array                      ctrl,
    output logic [c3sram_pkg::NUM_COLS-1:0] sense_data_o,
    output logic                            sense_valid_o
);
    import c3sram_pkg::*;

    logic [NUM_COLS-1:0] cells [NUM_ROWS];
    logic [ADDR_W-1:0]   sel_row;
    logic                wl_active;
    logic                wr_en;
    logic                sense_en;

    assign wl_active = |ctrl.wl;
    assign wr_en     = ctrl.w2b && ctrl.nprecharge;
    assign sense_en  = ctrl.saen && wl_active;

    // Index of the active word line
    always_comb begin
        sel_row = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ctrl.wl[r]) begin
                sel_row = ADDR_W'(r);
            end
        end
    end

    // Cells reset to zero and take write data on selected columns only
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                cells[r] <= '0;
            end
        end else if (wr_en) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (ctrl.wl[r]) begin
                    cells[r] <= (cells[r] & ~ctrl.csel) | (ctrl.wr_data & ctrl.csel);
                end
            end
        end
    end

    // Sense amplifier output lands one cycle after saen
    always_ff @(posedge clk) begin
        if (sense_en) begin
            sense_data_o <= cells[sel_row] & ctrl.csel;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sense_valid_o <= 1'b0;
        end else begin
            sense_valid_o <= sense_en;
        end
    end

endmodule

`default_nettype wire

// File: hw/c3sram_pkg.sv
// ##########################################################
// C3SRAM subsystem package
// Array geometry, queue depths, credit counts, the command
// record and the row-operation waveform tables
// ##########################################################
`default_nettype none

package c3sram_pkg;

    // Array geometry
    localparam int NUM_ROWS = 32;
    localparam int NUM_COLS = 32;
    localparam int ADDR_W   = $clog2(NUM_ROWS);

    // Command FIFO depth and the host's initial command credits
    localparam int CMD_DEPTH = 4;
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

    // Result credits held by the egress after reset
    localparam int RD_CREDITS = 2;
    localparam int RD_CNT_W   = $clog2(RD_CREDITS + 1);

    // Waveform tables indexed by the down-counting phase (3 first, 0 last)
    localparam logic [3:0] WR_W2B_WAVE  = 4'b1111;
    localparam logic [3:0] WR_NPRE_WAVE = 4'b1111;
    localparam logic [3:0] WR_WL_WAVE   = 4'b0110;
    localparam logic [3:0] WR_CSEL_WAVE = 4'b0110;

    localparam logic [3:0] RD_SAEN_WAVE = 4'b0010;
    localparam logic [3:0] RD_NPRE_WAVE = 4'b1110;
    localparam logic [3:0] RD_WL_WAVE   = 4'b0110;
    localparam logic [3:0] RD_CSEL_WAVE = 4'b0010;

    typedef struct packed {
        logic                write;
        logic [ADDR_W-1:0]   addr;
        logic [NUM_COLS-1:0] data;
    } cmd_t;

endpackage

`default_nettype wire

// File: hw/c3sram_top.sv
// ##########################################################
// C3SRAM subsystem top
// Command FIFO, row controller, bitcell array and result
// egress behind two credit-controlled host ports
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module c3sram_top (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            cmd_valid_i,
    input  logic                            cmd_write_i,
    input  logic [c3sram_pkg::ADDR_W-1:0]   cmd_addr_i,
    input  logic [c3sram_pkg::NUM_COLS-1:0] cmd_data_i,
    output logic                            cmd_credit_o,
    output logic                            rd_valid_o,
    output logic [c3sram_pkg::NUM_COLS-1:0] rd_data_o,
    input  logic                            rd_credit_i
);
    import c3sram_pkg::*;

    cmd_t                cmd_in;
    cmd_t                cmd_head;
    logic                cmd_avail;
    logic                cmd_pop;
    logic                rd_credit_avail;
    logic                rd_take;
    logic [NUM_COLS-1:0] sense_data;
    logic                sense_valid;

    sram_ctrl_if u_ctrl_if ();

    assign cmd_in = '{write: cmd_write_i, addr: cmd_addr_i, data: cmd_data_i};

    cmd_ingress u_cmd_ingress (
        .clk          (clk),
        .nrst         (nrst),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_in),
        .cmd_pop_i    (cmd_pop),
        .cmd_avail_o  (cmd_avail),
        .cmd_head_o   (cmd_head),
        .cmd_credit_o (cmd_credit_o)
    );

    wr_controller u_wr_controller (
        .clk               (clk),
        .nrst              (nrst),
        .cmd_avail_i       (cmd_avail),
        .cmd_head_i        (cmd_head),
        .cmd_pop_o         (cmd_pop),
        .rd_credit_avail_i (rd_credit_avail),
        .rd_take_o         (rd_take),
        .ctrl              (u_ctrl_if)
    );

    c3sram_array u_c3sram_array (
        .clk           (clk),
        .nrst          (nrst),
        .ctrl          (u_ctrl_if),
        .sense_data_o  (sense_data),
        .sense_valid_o (sense_valid)
    );

    rd_egress u_rd_egress (
        .clk               (clk),
        .nrst              (nrst),
        .sense_data_i      (sense_data),
        .sense_valid_i     (sense_valid),
        .rd_take_i         (rd_take),
        .rd_credit_avail_o (rd_credit_avail),
        .rd_credit_i       (rd_credit_i),
        .rd_valid_o        (rd_valid_o),
        .rd_data_o         (rd_data_o)
    );

endmodule

`default_nettype wire

// File: hw/cmd_ingress.sv
// ##########################################################
// Command ingress
// Circular command FIFO fed by credited host pushes; every
// entry that leaves returns one credit to the host
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module cmd_ingress (
    input  logic               clk,
    input  logic               nrst,
    input  logic               cmd_valid_i,
    input  c3sram_pkg::cmd_t   cmd_i,
    input  logic               cmd_pop_i,
    output logic               cmd_avail_o,
    output c3sram_pkg::cmd_t   cmd_head_o,
    output logic               cmd_credit_o
);
    import c3sram_pkg::*;

    cmd_t                 fifo_mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr_q;
    logic [CMD_PTR_W-1:0] rd_ptr_q;
    logic [CMD_CNT_W-1:0] count_q;
    logic                 push;
    logic                 pop;

    // Every push is backed by a host credit
    assign push = cmd_valid_i;
    assign pop  = cmd_pop_i && cmd_avail_o;

    assign cmd_avail_o = (count_q != '0);
    assign cmd_head_o  = fifo_mem[rd_ptr_q];

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= cmd_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // One credit back per popped entry
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_credit_o <= 1'b0;
        end else begin
            cmd_credit_o <= pop;
        end
    end

endmodule

`default_nettype wire

// File: hw/rd_egress.sv
// ##########################################################
// Result egress
// Registers sensed rows into one-cycle result pulses and
// tracks the result credits granted by the host
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module rd_egress (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic [c3sram_pkg::NUM_COLS-1:0] sense_data_i,
    input  logic                            sense_valid_i,
    input  logic                            rd_take_i,
    output logic                            rd_credit_avail_o,
    input  logic                            rd_credit_i,
    output logic                            rd_valid_o,
    output logic [c3sram_pkg::NUM_COLS-1:0] rd_data_o
);
    import c3sram_pkg::*;

    logic [RD_CNT_W-1:0] credit_cnt_q;

    assign rd_credit_avail_o = (credit_cnt_q != '0);

    // Take and return may land in the same cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credit_cnt_q <= RD_CNT_W'(RD_CREDITS);
        end else begin
            case ({rd_take_i, rd_credit_i})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= sense_valid_i;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (sense_valid_i) begin
            rd_data_o <= sense_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/sram_ctrl_if.sv
// ##########################################################
// SRAM control interface
// Analog control waveforms and write data from the row
// controller to the bitcell array
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

interface sram_ctrl_if;
    import c3sram_pkg::*;

    logic [NUM_COLS-1:0] csel;
    logic                saen;
    logic                w2b;
    logic                nprecharge;
    // One-hot word line select
    logic [NUM_ROWS-1:0] wl;
    logic [NUM_COLS-1:0] wr_data;

    modport controller (
        output csel,
        output saen,
        output w2b,
        output nprecharge,
        output wl,
        output wr_data
    );

    modport array (
        input csel,
        input saen,
        input w2b,
        input nprecharge,
        input wl,
        input wr_data
    );

endinterface

`default_nettype wire

// File: hw/wr_controller.sv
// ##########################################################
// Row controller
// Accepts queued commands and plays the four-phase write or
// read waveforms (wl, w2b, precharge, saen, csel) onto the
// array; reads reserve a result credit first
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module wr_controller (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    cmd_avail_i,
    input  c3sram_pkg::cmd_t        cmd_head_i,
    output logic                    cmd_pop_o,
    input  logic                    rd_credit_avail_i,
    output logic                    rd_take_o,
    sram_ctrl_if.controller         ctrl
);
    import c3sram_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_WRITING = 2'd1,
        S_READING = 2'd2
    } ctrl_state_t;

    ctrl_state_t         state_q;
    ctrl_state_t         state_d;
    logic [1:0]          pos_ctr;
    logic [ADDR_W-1:0]   addr_q;
    logic [NUM_COLS-1:0] data_q;
    logic                ready;
    logic                done;
    logic                accept_wr;
    logic                accept_rd;
    logic [NUM_ROWS-1:0] wl_d;

    assign ready = (state_q == S_IDLE);
    // Last busy cycle of either operation
    assign done  = (state_q != S_IDLE) && (pos_ctr == 2'd0);

    assign accept_wr = ready && cmd_avail_i && cmd_head_i.write;
    // Reads wait at the head until the egress can take a result
    assign accept_rd = ready && cmd_avail_i && !cmd_head_i.write && rd_credit_avail_i;

    // Head leaves the FIFO in the first busy cycle
    assign cmd_pop_o = (state_q != S_IDLE) && (pos_ctr == 2'd3);
    assign rd_take_o = (state_q == S_READING) && (pos_ctr == 2'd3);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept_wr) begin
                    state_d = S_WRITING;
                end else if (accept_rd) begin
                    state_d = S_READING;
                end
            end
            S_WRITING, S_READING: begin
                if (done) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Latch the accepted command
    always_ff @(posedge clk) begin
        if (accept_wr || accept_rd) begin
            addr_q <= cmd_head_i.addr;
            data_q <= cmd_head_i.data;
        end
    end

    // Phase counter runs 3 down to 0 while busy
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pos_ctr <= 2'd3;
        end else if (state_q == S_IDLE) begin
            pos_ctr <= 2'd3;
        end else begin
            pos_ctr <= pos_ctr - 2'd1;
        end
    end

    // Waveform generation
    always_comb begin
        wl_d            = '0;
        ctrl.csel       = '0;
        ctrl.saen       = 1'b0;
        ctrl.w2b        = 1'b0;
        ctrl.nprecharge = 1'b0;
        case (state_q)
            S_WRITING: begin
                wl_d[addr_q]    = WR_WL_WAVE[pos_ctr];
                ctrl.csel       = {NUM_COLS{WR_CSEL_WAVE[pos_ctr]}};
                ctrl.w2b        = WR_W2B_WAVE[pos_ctr];
                ctrl.nprecharge = WR_NPRE_WAVE[pos_ctr];
            end
            S_READING: begin
                wl_d[addr_q]    = RD_WL_WAVE[pos_ctr];
                ctrl.csel       = {NUM_COLS{RD_CSEL_WAVE[pos_ctr]}};
                ctrl.saen       = RD_SAEN_WAVE[pos_ctr];
                ctrl.nprecharge = RD_NPRE_WAVE[pos_ctr];
            end
            default: begin
                wl_d = '0;
            end
        endcase
    end

    assign ctrl.wl      = wl_d;
    assign ctrl.wr_data = data_q;

endmodule

`default_nettype wire

// File: verification/c3sram_checker.sv
// ##########################################################
// C3SRAM protocol checker
// Word line, sense and write exclusion, FIFO occupancy and
// result credit bounds, bound into the subsystem top
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module c3sram_checker (
    input logic                               clk,
    input logic                               nrst,
    input logic [c3sram_pkg::NUM_ROWS-1:0]    wl_i,
    input logic                               w2b_i,
    input logic                               saen_i,
    input logic [c3sram_pkg::CMD_CNT_W-1:0]   occupancy_i,
    input logic [c3sram_pkg::RD_CNT_W-1:0]    rd_credits_i
);
    import c3sram_pkg::*;

    wl_onehot: assert property (@(posedge clk) disable iff (!nrst) $onehot0(wl_i))
        else $error("word lines not zero or one-hot: %h", wl_i);

    // Driving the bitlines while sensing would corrupt the read
    w2b_saen_excl: assert property (@(posedge clk) disable iff (!nrst) !(w2b_i && saen_i))
        else $error("w2b and saen high in the same cycle");

    // A push into a full FIFO shows up as an overflowing count
    fifo_bound: assert property (@(posedge clk) disable iff (!nrst)
        occupancy_i <= CMD_CNT_W'(CMD_DEPTH))
        else $error("command FIFO occupancy %0d above depth", occupancy_i);

    credit_bound: assert property (@(posedge clk) disable iff (!nrst)
        rd_credits_i <= RD_CNT_W'(RD_CREDITS))
        else $error("result credit count %0d above its limit", rd_credits_i);

endmodule

bind c3sram_top c3sram_checker u_c3sram_checker (
    .clk          (clk),
    .nrst         (nrst),
    .wl_i         (u_ctrl_if.wl),
    .w2b_i        (u_ctrl_if.w2b),
    .saen_i       (u_ctrl_if.saen),
    .occupancy_i  (u_cmd_ingress.count_q),
    .rd_credits_i (u_rd_egress.credit_cnt_q)
);

`default_nettype wire

// File: verification/c3sram_tb.sv
// ##########################################################
// C3SRAM subsystem testbench
// Table-driven row commands over the credited command port,
// reference memory, in-order result checks and a stall phase
// with withheld result credits
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module c3sram_tb;
    import c3sram_pkg::*;

    localparam logic [31:0] SEED = 32'ha317_ae13;
    localparam int TABLE_LEN    = 27;
    localparam int DRAIN_CYCLES = 10;
    // Minimum silence on cmd_credit_o before the end of a stall
    localparam int CREDIT_QUIET = 16;

    // Table columns are write flag, row, idle cycles after and result credit hold cycles
    localparam int STEPS [TABLE_LEN][4] = '{
        '{0, 0, 0, 0}, '{0, 17, 1, 0}, '{0, 31, 2, 0},
        '{1, 3, 0, 0}, '{0, 3, 3, 0},
        '{1, 7, 0, 0}, '{1, 12, 1, 0}, '{1, 20, 0, 0}, '{1, 1, 0, 0},
        '{0, 20, 0, 0}, '{0, 1, 0, 0}, '{0, 7, 2, 0}, '{0, 12, 0, 0},
        '{1, 12, 0, 0}, '{0, 12, 0, 0}, '{1, 7, 0, 0}, '{0, 7, 4, 0},
        '{0, 20, 0, 40}, '{0, 3, 0, 0}, '{0, 12, 0, 0}, '{0, 1, 0, 0},
        '{1, 20, 0, 0}, '{0, 7, 0, 0}, '{0, 20, 0, 0}, '{0, 0, 0, 0},
        '{1, 5, 0, 0}, '{0, 5, 0, 0}
    };

    logic                clk;
    logic                nrst;
    logic                cmd_valid_i;
    logic                cmd_write_i;
    logic [ADDR_W-1:0]   cmd_addr_i;
    logic [NUM_COLS-1:0] cmd_data_i;
    logic                cmd_credit_o;
    logic                rd_valid_o;
    logic [NUM_COLS-1:0] rd_data_o;
    logic                rd_credit_i;

    logic [NUM_COLS-1:0] ref_mem [NUM_ROWS];
    logic [NUM_COLS-1:0] exp_q [$];
    int                  row_q [$];
    logic [31:0]         rng_state;
    int                  cycle;
    int                  host_credits;
    int                  pushes;
    int                  credit_pulses;
    int                  reads_issued;
    int                  results;
    int                  checks;
    int                  errors;
    int                  owed;
    int                  window_results;
    int                  hold_end;
    int                  last_credit_cycle;
    bit                  withhold;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .nrst_o (nrst)
    );

    c3sram_top u_c3sram_top (
        .clk          (clk),
        .nrst         (nrst),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_write_i  (cmd_write_i),
        .cmd_addr_i   (cmd_addr_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_credit_o (cmd_credit_o),
        .rd_valid_o   (rd_valid_o),
        .rd_data_o    (rd_data_o),
        .rd_credit_i  (rd_credit_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Results come back in command order
    task automatic check_result();
        logic [NUM_COLS-1:0] exp;
        int                  row;
        results++;
        checks++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Result on rd_valid_o arrived with no read outstanding");
        end else begin
            exp = exp_q.pop_front();
            row = row_q.pop_front();
            if (rd_data_o !== exp) begin
                errors++;
                $display("FAILED rd_data_o row %0d: expected %08h, got %08h",
                         row, exp, rd_data_o);
            end
        end
    endtask

    // Advance to the next falling edge, then close a stall, return credits and sample outputs
    task automatic tick();
        @(negedge clk);
        cycle++;
        if (withhold && cycle >= hold_end) begin
            withhold = 1'b0;
            checks += 3;
            if (window_results > RD_CREDITS) begin
                errors++;
                $display("%0d results arrived while result credits were withheld",
                         window_results);
            end
            if (cycle - last_credit_cycle < CREDIT_QUIET) begin
                errors++;
                $display("cmd_credit_o kept pulsing while the read at the head was stalled");
            end
            if (host_credits != 0) begin
                errors++;
                $display("Host still held %0d command credits at the end of the stall",
                         host_credits);
            end
        end
        rd_credit_i = 1'b0;
        if (!withhold && owed > 0) begin
            rd_credit_i = 1'b1;
            owed--;
        end
        if (cmd_credit_o) begin
            host_credits++;
            credit_pulses++;
            if (withhold) begin
                last_credit_cycle = cycle;
            end
        end
        if (rd_valid_o) begin
            check_result();
            owed++;
            if (withhold) begin
                window_results++;
            end
        end
    endtask

    task automatic issue_cmd(input int idx);
        logic [NUM_COLS-1:0] wdata;
        int                  row;
        wdata = '0;
        row   = STEPS[idx][1];
        if (STEPS[idx][0] != 0) begin
            rng_state    = lcg_next(rng_state);
            wdata        = rng_state;
            ref_mem[row] = wdata;
        end else begin
            exp_q.push_back(ref_mem[row]);
            row_q.push_back(row);
            reads_issued++;
        end
        cmd_valid_i = 1'b1;
        cmd_write_i = (STEPS[idx][0] != 0);
        cmd_addr_i  = ADDR_W'(row);
        cmd_data_i  = wdata;
        host_credits--;
        pushes++;
    endtask

    initial begin : stimulus
        cmd_valid_i = 1'b0;
        cmd_write_i = 1'b0;
        cmd_addr_i  = '0;
        cmd_data_i  = '0;
        rd_credit_i = 1'b0;
        rng_state   = SEED;
        host_credits = CMD_DEPTH;
        for (int r = 0; r < NUM_ROWS; r++) begin
            ref_mem[r] = '0;
        end
        @(posedge nrst);
        tick();
        checks++;
        if (cmd_credit_o !== 1'b0 || rd_valid_o !== 1'b0) begin
            errors++;
            $display("Outputs not idle after reset");
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            // Start a stall from an empty result path
            if (STEPS[i][3] > 0) begin
                while (exp_q.size() != 0 || owed != 0) begin
                    tick();
                end
                withhold          = 1'b1;
                hold_end          = cycle + STEPS[i][3];
                last_credit_cycle = cycle;
                window_results    = 0;
            end
            while (host_credits == 0) begin
                tick();
            end
            issue_cmd(i);
            tick();
            cmd_valid_i = 1'b0;
            repeat (STEPS[i][2]) begin
                tick();
            end
        end
        while (exp_q.size() != 0 || withhold) begin
            tick();
        end
        repeat (DRAIN_CYCLES) begin
            tick();
        end
        checks += 2;
        if (results != reads_issued) begin
            errors++;
            $display("Got %0d results for %0d reads issued", results, reads_issued);
        end
        if (credit_pulses != pushes) begin
            errors++;
            $display("Got %0d command credits back for %0d commands pushed",
                     credit_pulses, pushes);
        end
        $display("Summary: %0d checks, %0d errors, %0d reads, %0d results, %0d commands",
                 checks, errors, reads_issued, results, pushes);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int max_hold;
        int count;
        max_hold = 0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (STEPS[i][3] > max_hold) begin
                max_hold = STEPS[i][3];
            end
        end
        limit = TABLE_LEN * 12 + max_hold + 100;
        count = 0;
        while (count < limit) begin
            @(posedge clk);
            count++;
        end
        $display("Timeout after %0d cycles, the run did not complete", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clkgen.sv
// ##########################################################
// Testbench clock and reset
// 10 ns clock, active-low reset held for two cycles
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset releases on a falling edge away from the sampling edge
    initial begin
        nrst_o = 1'b0;
        repeat (2) @(negedge clk_o);
        nrst_o = 1'b1;
    end

endmodule

`default_nettype wire
